// File: files.f
rtl/agcPkg.sv
rtl/agcLoopRegs.sv
rtl/agcLevelDetector.sv
rtl/agcLoopFilter.sv
rtl/agcSubsystem.sv
verif/agcLoop_checker.sv
verif/agcTb.sv

// File: rtl/agcLevelDetector.sv
`timescale 1ns/10ps

module agcLevelDetector import agcPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  agcSample_t adcSample,
    output agcLevel_t signalLevel,
    output agcLog_t log2SignalLevel
);

    logic signed [agcLevelWidth-1:0] sampleExt;
    agcLevel_t magnitude;
    agcLevel_t average;
    logic signed [agcLevelWidth:0] avgDiff;
    logic signed [agcLevelWidth:0] avgStep;
    logic signed [agcLevelWidth:0] avgSum;
    agcLevel_t avgNext;
    logic [4:0] msbPos;
    logic [agcLevelWidth+2:0] avgPadded;
    logic [2:0] logFraction;
    agcLog_t logNext;

    // Index of the highest set bit or zero when no bit is set.
    function automatic logic [4:0] msbIndex(agcLevel_t value);
        logic [4:0] index;
        index = '0;
        for (int i = 0; i < agcLevelWidth; i++) begin
            if (value[i]) begin
                index = 5'(i);
            end
        end
        return index;
    endfunction

    assign sampleExt = {adcSample[agcSampleWidth-1], adcSample};
    assign magnitude = sampleExt[agcLevelWidth-1] ? agcLevel_t'(-sampleExt)
                                                  : agcLevel_t'(sampleExt);  // -32768 gives 32768.

    // the first order averager adds (mag - avg) >>> shift to the average.
    assign avgDiff = $signed({1'b0, magnitude}) - $signed({1'b0, average});
    assign avgStep = avgDiff >>> agcAvgShift;
    assign avgSum = $signed({1'b0, average}) + avgStep;
    assign avgNext = avgSum[agcLevelWidth-1:0];  // the sum never leaves the 17-bit range.

    // The fraction is the three bits below the leading one with zeros shifted in for small values.
    assign msbPos = msbIndex(avgNext);
    assign avgPadded = {avgNext, 3'b000};
    assign logFraction = avgPadded[msbPos +: 3];
    assign logNext = (avgNext == '0) ? '0 : {msbPos, logFraction};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            average <= '0;
            log2SignalLevel <= '0;
        end else if (clkEn) begin
            average <= avgNext;
            log2SignalLevel <= logNext;  // registered with the same strobe as the average.
        end
    end

    assign signalLevel = average;

endmodule

// File: rtl/agcLoopFilter.sv
`timescale 1ns/10ps

module agcLoopFilter import agcPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  agcBusReq_t busReq,
    output agcWord_t busRdData,
    input  agcLevel_t signalLevel,
    input  agcLog_t log2SignalLevel,
    output agcWord_t loopOutput
);

    agcLoopCfg_t cfg;
    agcWord_t integrator;
    agcError_t linearError;
    logic signed [8:0] logError;
    agcError_t rawError;
    agcError_t errorNext;
    agcError_t loopError;
    agcGain_t loopGain;
    logic signed [agcWordWidth-1:0] errorExt;
    logic signed [agcWordWidth-1:0] leadNext;
    agcWord_t leadError;
    logic signed [agcWordWidth:0] integSum;

    agcLoopRegs loopRegs_i (
        .clk(clk),
        .reset(reset),
        .busReq(busReq),
        .busRdData(busRdData),
        .cfg(cfg),
        .integrator(integrator),
        .signalLevel(signalLevel),
        .log2SignalLevel(log2SignalLevel)
    );

    // Stage 1 compares the chosen level with the setpoint.
    assign linearError = $signed({1'b0, cfg.setpoint}) - $signed({1'b0, signalLevel});
    assign logError = $signed({1'b0, cfg.setpoint[7:0]}) - $signed({1'b0, log2SignalLevel});
    assign rawError = cfg.useLinear ? linearError : {logError, 9'b0};  // log error scaled by 512.

    always_comb begin
        if (cfg.zeroError) begin
            errorNext = '0;
        end else if (cfg.invertError) begin
            errorNext = -rawError;
        end else begin
            errorNext = rawError;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loopError <= '0;
        end else if (clkEn) begin
            loopError <= errorNext;
        end
    end

    // Stage 2 scales by 2**(gain - 17); a gain of 17 passes the error unchanged.
    assign loopGain = loopError[agcErrorWidth-1] ? cfg.negErrorGain : cfg.posErrorGain;
    assign errorExt = {{(agcWordWidth-agcErrorWidth){loopError[agcErrorWidth-1]}}, loopError};

    always_comb begin
        if (loopGain >= 5'd17) begin
            leadNext = errorExt <<< (loopGain - 5'd17);
        end else begin
            leadNext = errorExt >>> (5'd17 - loopGain);  // floors toward minus infinity.
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadError <= '0;
        end else if (clkEn) begin
            leadError <= agcWord_t'(leadNext);
        end
    end

    // Stage 3 adds the signed lead error to the unsigned integrator with one guard bit.
    assign integSum = $signed({1'b0, integrator})
                    + $signed({leadError[agcWordWidth-1], leadError});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            integrator <= '0;
        end else if (clkEn) begin
            if (leadError[agcWordWidth-1] && integSum[agcWordWidth]) begin
                integrator <= cfg.lowerLimit;  // wrapped below zero.
            end else if (!leadError[agcWordWidth-1] && integSum[agcWordWidth]) begin
                integrator <= cfg.upperLimit;  // wrapped past full scale.
            end else if (integSum[agcWordWidth-1:0] >= cfg.upperLimit) begin
                integrator <= cfg.upperLimit;
            end else if (integSum[agcWordWidth-1:0] <= cfg.lowerLimit) begin
                integrator <= cfg.lowerLimit;
            end else begin
                integrator <= integSum[agcWordWidth-1:0];
            end
        end
    end

    assign loopOutput = integrator;  // gain command for the front-end attenuator.

endmodule

// File: rtl/agcLoopRegs.sv
`timescale 1ns/10ps

module agcLoopRegs import agcPkg::*; (
    input  logic clk,
    input  logic reset,
    input  agcBusReq_t busReq,
    output agcWord_t busRdData,
    output agcLoopCfg_t cfg,
    input  agcWord_t integrator,
    input  agcLevel_t signalLevel,
    input  agcLog_t log2SignalLevel
);

    agcWord_t ctrlReg;
    agcWord_t gainReg;
    agcWord_t upperReg;
    agcWord_t lowerReg;
    logic writeCycle;

    // Replace only the byte lanes whose strobe is set.
    function automatic agcWord_t mergeLanes(agcWord_t oldWord, agcWord_t newWord,
                                            logic [3:0] laneMask);
        agcWord_t merged;
        merged = oldWord;
        for (int lane = 0; lane < 4; lane++) begin
            if (laneMask[lane]) begin
                merged[lane*8 +: 8] = newWord[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign writeCycle = busReq.cs && (|busReq.byteWrite);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlReg <= agcCtrlReset;
            gainReg <= agcGainReset;
            upperReg <= agcUpperReset;
            lowerReg <= agcLowerReset;
        end else if (writeCycle) begin
            // the read-only addresses fall through and change nothing.
            if (busReq.addr == agcCtrlAddr) begin
                ctrlReg <= mergeLanes(ctrlReg, busReq.wrData, busReq.byteWrite);
            end
            if (busReq.addr == agcGainAddr) begin
                gainReg <= mergeLanes(gainReg, busReq.wrData, busReq.byteWrite);
            end
            if (busReq.addr == agcUpperAddr) begin
                upperReg <= mergeLanes(upperReg, busReq.wrData, busReq.byteWrite);
            end
            if (busReq.addr == agcLowerAddr) begin
                lowerReg <= mergeLanes(lowerReg, busReq.wrData, busReq.byteWrite);
            end
        end
    end

    assign cfg.setpoint = ctrlReg[16:0];
    assign cfg.invertError = ctrlReg[24];
    assign cfg.zeroError = ctrlReg[25];
    assign cfg.useLinear = ctrlReg[26];
    assign cfg.posErrorGain = gainReg[4:0];
    assign cfg.negErrorGain = gainReg[12:8];
    assign cfg.upperLimit = upperReg;
    assign cfg.lowerLimit = lowerReg;

    // Reads are combinational and return zero when the block is not selected.
    always_comb begin
        busRdData = '0;
        if (busReq.cs) begin
            case (busReq.addr)
                agcCtrlAddr: busRdData = ctrlReg;
                agcGainAddr: busRdData = gainReg;
                agcUpperAddr: busRdData = upperReg;
                agcLowerAddr: busRdData = lowerReg;
                agcIntegAddr: busRdData = integrator;
                agcLevelAddr: busRdData = {log2SignalLevel, 7'b0, signalLevel};  // log in 31:24.
                default: busRdData = '0;  // unmapped addresses read as zero.
            endcase
        end
    end

endmodule

// File: rtl/agcPkg.sv
package agcPkg;

    localparam int agcSampleWidth = 16;
    localparam int agcLevelWidth = 17;
    localparam int agcLogWidth = 8;
    localparam int agcErrorWidth = 18;
    localparam int agcGainWidth = 5;
    localparam int agcWordWidth = 32;
    localparam int agcAddrWidth = 13;

    typedef logic signed [agcSampleWidth-1:0] agcSample_t;  // two's complement ADC sample.
    typedef logic [agcLevelWidth-1:0] agcLevel_t;           // linear level that is never negative.
    typedef logic [agcLogWidth-1:0] agcLog_t;               // 5.3 log2 level.
    typedef logic signed [agcErrorWidth-1:0] agcError_t;
    typedef logic [agcGainWidth-1:0] agcGain_t;
    typedef logic [agcWordWidth-1:0] agcWord_t;
    typedef logic [agcAddrWidth-1:0] agcAddr_t;

    typedef struct packed {
        logic cs;
        logic [3:0] byteWrite;  // one strobe per byte lane with bit 0 for the low byte.
        agcAddr_t addr;
        agcWord_t wrData;
    } agcBusReq_t;

    typedef struct packed {
        agcLevel_t setpoint;
        logic invertError;
        logic zeroError;
        logic useLinear;
        agcGain_t posErrorGain;
        agcGain_t negErrorGain;
        agcWord_t upperLimit;
        agcWord_t lowerLimit;
    } agcLoopCfg_t;

    localparam agcAddr_t agcCtrlAddr = 13'h000;
    localparam agcAddr_t agcGainAddr = 13'h004;
    localparam agcAddr_t agcUpperAddr = 13'h008;
    localparam agcAddr_t agcLowerAddr = 13'h00C;
    localparam agcAddr_t agcIntegAddr = 13'h010;  // read only.
    localparam agcAddr_t agcLevelAddr = 13'h014;  // read only.

    localparam agcWord_t agcCtrlReset = 32'h0200_0000;  // zeroError set so the loop idles.
    localparam agcWord_t agcGainReset = 32'h0000_0000;
    localparam agcWord_t agcUpperReset = 32'hFFFF_FFFF;
    localparam agcWord_t agcLowerReset = 32'h0000_0000;

    localparam int agcAvgShift = 4;  // averager time constant is 2**agcAvgShift samples.

endpackage

// File: rtl/agcSubsystem.sv
`timescale 1ns/10ps

module agcSubsystem import agcPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  agcSample_t adcSample,
    input  agcBusReq_t busReq,
    output agcWord_t busRdData,
    output agcWord_t loopOutput
);

    agcLevel_t signalLevel;
    agcLog_t log2SignalLevel;

    // the detector measures the input and the filter closes the loop on that level.
    agcLevelDetector levelDetector_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .adcSample(adcSample),
        .signalLevel(signalLevel),
        .log2SignalLevel(log2SignalLevel)
    );

    agcLoopFilter loopFilter_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .busReq(busReq),
        .busRdData(busRdData),
        .signalLevel(signalLevel),
        .log2SignalLevel(log2SignalLevel),
        .loopOutput(loopOutput)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the AGC testbench with Verilator, runs it and checks the result line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module agcTb -Mdir obj_dir \
    && ./obj_dir/VagcTb | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/agcLoop_checker.sv
`timescale 1ns/10ps

module agcLoopChecker import agcPkg::*; (
    input logic clk,
    input logic reset,
    input logic clkEn,
    input agcLoopCfg_t cfg,
    input agcWord_t integrator,
    input agcError_t loopError,
    input agcWord_t leadError
);

    // after a strobe the integrator sits inside the limits that were active at that strobe.
    property integInLimits;
        @(posedge clk) disable iff (reset)
        (clkEn && (cfg.lowerLimit <= cfg.upperLimit))
            |=> (integrator >= $past(cfg.lowerLimit) && integrator <= $past(cfg.upperLimit));
    endproperty

    property zeroClearsError;
        @(posedge clk) disable iff (reset)
        (clkEn && cfg.zeroError) |=> (loopError == '0);
    endproperty

    // Without a strobe every pipeline register keeps its value.
    property holdWithoutStrobe;
        @(posedge clk) disable iff (reset)
        !clkEn |=> ($stable(loopError) && $stable(leadError) && $stable(integrator));
    endproperty

    integInLimitsA: assert property (integInLimits) else $error("integrator left its limits");
    zeroClearsErrorA: assert property (zeroClearsError) else $error("loopError not cleared");
    holdWithoutStrobeA: assert property (holdWithoutStrobe) else $error("loop state moved");

endmodule

// File: verif/agcTb.sv
`timescale 1ns/10ps

module agcTb import agcPkg::*; ();

    logic clk = 1'b0;
    logic reset;
    logic clkEn;
    agcSample_t adcSample;
    agcBusReq_t busReq;
    agcWord_t busRdData;
    agcWord_t loopOutput;

    logic [31:0] rngState;
    logic streamOn;
    int sampleShift;
    int errorCount;
    int testsRun;
    int testsFailed;
    int testStartErrors;

    // model state is updated at every rising edge.
    agcWord_t shadowCtrl;
    agcWord_t shadowGain;
    agcWord_t shadowUpper;
    agcWord_t shadowLower;
    int mAvg;
    int mLog;
    int mLoopErr;
    agcWord_t mLead;
    agcWord_t mInteg;
    int strobeCount;
    int wrapHighCount;
    int wrapLowCount;

    agcSubsystem agcSubsystem_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .adcSample(adcSample),
        .busReq(busReq),
        .busRdData(busRdData),
        .loopOutput(loopOutput)
    );

    bind agcLoopFilter agcLoopChecker loopChecker_i (
        .clk(clk),
        .reset(reset),
        .clkEn(clkEn),
        .cfg(cfg),
        .integrator(integrator),
        .loopError(loopError),
        .leadError(leadError)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int log2Level(int avg);
        int k;
        k = 0;
        if (avg == 0) begin
            return 0;
        end
        while ((avg >> (k + 1)) != 0) begin
            k++;
        end
        if (k >= 3) begin
            return k * 8 + ((avg >> (k - 3)) & 7);
        end
        return k * 8 + ((avg << (3 - k)) & 7);  // small averages pad the fraction with zeros.
    endfunction

    function automatic int loopErrorFor(int level, int logLevel);
        int err;
        if (shadowCtrl[25]) begin
            return 0;
        end
        if (shadowCtrl[26]) begin
            err = int'(shadowCtrl[16:0]) - level;
        end else begin
            err = (int'(shadowCtrl[7:0]) - logLevel) * 512;
        end
        return shadowCtrl[24] ? -err : err;
    endfunction

    function automatic agcWord_t leadFor(int err);
        int gain;
        longint wide;
        gain = (err < 0) ? int'(shadowGain[12:8]) : int'(shadowGain[4:0]);
        wide = longint'(err);
        if (gain >= 17) begin
            wide = wide * (longint'(1) << (gain - 17));
        end else begin
            wide = wide >>> (17 - gain);  // arithmetic shift floors the result.
        end
        return agcWord_t'(wide);
    endfunction

    function automatic agcWord_t byteMerge(agcWord_t oldWord, agcWord_t newWord, logic [3:0] be);
        agcWord_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (oldWord & ~mask) | (newWord & mask);
    endfunction

    function automatic agcWord_t expectedRead(agcAddr_t addr);
        case (addr)
            agcCtrlAddr: return shadowCtrl;
            agcGainAddr: return shadowGain;
            agcUpperAddr: return shadowUpper;
            agcLowerAddr: return shadowLower;
            agcIntegAddr: return mInteg;
            agcLevelAddr: return {agcLog_t'(mLog), 7'b0, agcLevel_t'(mAvg)};
            default: return '0;
        endcase
    endfunction

    function automatic agcWord_t ctrlWord(logic [16:0] setpoint, bit invert, bit zero, bit linear);
        agcWord_t word;
        word = '0;
        word[16:0] = setpoint;
        word[24] = invert;
        word[25] = zero;
        word[26] = linear;
        return word;
    endfunction

    function automatic agcWord_t gainWord(agcGain_t pos, agcGain_t neg);
        agcWord_t word;
        word = '0;
        word[4:0] = pos;
        word[12:8] = neg;
        return word;
    endfunction

    // the three pipeline stages see the values from before the edge and the bus write lands last.
    always @(posedge clk or posedge reset) begin : loopModel
        int magnitude;
        int nextAvg;
        int nextErr;
        agcWord_t nextLead;
        agcWord_t nextInteg;
        longint sum;
        agcWord_t wrWord;
        logic [3:0] wrLanes;
        if (reset) begin
            shadowCtrl = agcCtrlReset;
            shadowGain = agcGainReset;
            shadowUpper = agcUpperReset;
            shadowLower = agcLowerReset;
            mAvg = 0;
            mLog = 0;
            mLoopErr = 0;
            mLead = '0;
            mInteg = '0;
            strobeCount = 0;
            wrapHighCount = 0;
            wrapLowCount = 0;
        end else begin
            if (clkEn) begin
                magnitude = (adcSample < 0) ? -int'(adcSample) : int'(adcSample);
                nextAvg = mAvg + ((magnitude - mAvg) >>> agcAvgShift);
                nextErr = loopErrorFor(mAvg, mLog);
                nextLead = leadFor(mLoopErr);
                sum = longint'(mInteg) + longint'($signed(mLead));
                if (sum < 0) begin
                    nextInteg = shadowLower;
                    wrapLowCount++;
                end else if (sum > longint'(32'hFFFF_FFFF)) begin
                    nextInteg = shadowUpper;
                    wrapHighCount++;
                end else if (sum >= longint'(shadowUpper)) begin
                    nextInteg = shadowUpper;
                end else if (sum <= longint'(shadowLower)) begin
                    nextInteg = shadowLower;
                end else begin
                    nextInteg = agcWord_t'(sum);
                end
                mAvg = nextAvg;
                mLog = log2Level(nextAvg);
                mLoopErr = nextErr;
                mLead = nextLead;
                mInteg = nextInteg;
                strobeCount++;
            end
            if (busReq.cs && busReq.byteWrite != 4'b0) begin
                wrWord = busReq.wrData;
                wrLanes = busReq.byteWrite;
                case (busReq.addr)
                    agcCtrlAddr: shadowCtrl = byteMerge(shadowCtrl, wrWord, wrLanes);
                    agcGainAddr: shadowGain = byteMerge(shadowGain, wrWord, wrLanes);
                    agcUpperAddr: shadowUpper = byteMerge(shadowUpper, wrWord, wrLanes);
                    agcLowerAddr: shadowLower = byteMerge(shadowLower, wrWord, wrLanes);
                    default: ;
                endcase
            end
        end
    end

    // drives one clock of stimulus and compares the loop output at the falling edge.
    task automatic stepCycle(agcBusReq_t req);
        logic [31:0] r;
        agcSample_t raw;
        @(posedge clk);
        r = nextRandom();
        raw = r[31:16];
        clkEn <= streamOn & r[0];
        adcSample <= raw >>> sampleShift;
        busReq <= req;
        @(negedge clk);
        if (loopOutput !== mInteg) begin
            errorCount++;
            $display("Fail loopOutput: got 0x%08h expected 0x%08h at %0t",
                     loopOutput, mInteg, $time);
        end
    endtask

    task automatic busWrite(agcAddr_t addr, agcWord_t data, logic [3:0] mask);
        agcBusReq_t req;
        req = '0;
        req.cs = 1'b1;
        req.byteWrite = mask;
        req.addr = addr;
        req.wrData = data;
        stepCycle(req);
    endtask

    task automatic readCheck(agcAddr_t addr, agcWord_t expected, bit useModel);
        agcBusReq_t req;
        agcWord_t want;
        req = '0;
        req.cs = 1'b1;
        req.addr = addr;
        stepCycle(req);
        want = useModel ? expectedRead(addr) : expected;
        if (busRdData !== want) begin
            errorCount++;
            $display("Fail busRdData at 0x%03h: got 0x%08h expected 0x%08h",
                     addr, busRdData, want);
        end
    endtask

    task automatic waitStrobes(int count, int limit);
        int target;
        int cycles;
        target = strobeCount + count;
        cycles = 0;
        while (strobeCount < target && cycles < limit) begin
            stepCycle('0);
            cycles++;
        end
        if (strobeCount < target) begin
            errorCount++;
            $display("timeout: %0d sample strobes did not arrive in %0d cycles", count, limit);
        end
    endtask

    task automatic configureLoop(agcWord_t ctrl, agcWord_t gain, agcWord_t upper,
                                 agcWord_t lower);
        busWrite(agcUpperAddr, upper, 4'hF);
        busWrite(agcLowerAddr, lower, 4'hF);
        busWrite(agcGainAddr, gain, 4'hF);
        busWrite(agcCtrlAddr, ctrl, 4'hF);  // ctrl last so the loop starts on the final settings.
    endtask

    task automatic streamCycles(int cycles);
        for (int i = 0; i < cycles; i++) begin
            if (i % 16 == 15) begin
                readCheck(agcLevelAddr, '0, 1'b1);
            end else if (i % 16 == 7) begin
                readCheck(agcIntegAddr, '0, 1'b1);
            end else begin
                stepCycle('0);
            end
        end
    endtask

    task automatic finishTest(string name);
        int found;
        found = errorCount - testStartErrors;
        testsRun++;
        if (found == 0) begin
            $display("Test %0d %s: pass", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", testsRun, name, found);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        agcWord_t lower;
        agcWord_t hold;
        agcWord_t levelBefore;
        int highBefore;
        int lowBefore;
        rngState = 32'd84840;
        reset = 1'b1;
        clkEn = 1'b0;
        adcSample = '0;
        busReq = '0;
        streamOn = 1'b0;
        sampleShift = 0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        testStartErrors = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        readCheck(agcCtrlAddr, agcCtrlReset, 1'b0);
        readCheck(agcGainAddr, agcGainReset, 1'b0);
        readCheck(agcUpperAddr, agcUpperReset, 1'b0);
        readCheck(agcLowerAddr, agcLowerReset, 1'b0);
        readCheck(agcIntegAddr, '0, 1'b0);
        readCheck(agcLevelAddr, '0, 1'b0);
        readCheck(13'h018, '0, 1'b0);  // unmapped.
        stepCycle('{cs: 1'b0, byteWrite: 4'b0, addr: agcUpperAddr, wrData: '0});
        if (busRdData !== '0) begin
            errorCount++;
            $display("Fail busRdData with cs low: got 0x%08h expected 0x00000000", busRdData);
        end
        for (int i = 0; i < 24; i++) begin
            r = nextRandom();
            s = nextRandom();
            busWrite(agcAddr_t'((r % 6) * 4), s, r[11:8]);  // read-only addresses included.
            readCheck(agcAddr_t'((r % 6) * 4), '0, 1'b1);
        end
        finishTest("reset values and bus access");

        r = nextRandom();
        s = nextRandom();
        sampleShift = int'(r[2:0]);
        configureLoop(ctrlWord(r[26:10], 1'b0, 1'b0, 1'b1), gainWord(s[4:0], s[12:8]),
                      32'hFFFF_FFFF, '0);
        streamOn = 1'b1;
        streamCycles(300);
        finishTest("linear loop");

        r = nextRandom();
        s = nextRandom();
        sampleShift = int'(r[3:0]);
        configureLoop(ctrlWord(r[26:10], 1'b1, 1'b0, 1'b0), gainWord(s[4:0], s[12:8]),
                      32'hFFFF_FFFF, '0);
        streamCycles(300);
        finishTest("log mode with inverted error");

        for (int round = 0; round < 4; round++) begin
            r = nextRandom();
            s = nextRandom();
            lower = r & 32'h7FFF_FFFF;
            sampleShift = int'(s[18:16]);
            configureLoop(ctrlWord(s[31:15], 1'b0, 1'b0, 1'b1),
                          gainWord({2'b11, s[2:0]}, {2'b11, s[6:4]}),
                          lower + (s & 32'h0000_FFFF), lower);
            streamCycles(60);
        end
        highBefore = wrapHighCount;
        sampleShift = 15;  // near-silent input drives a large positive error.
        configureLoop(ctrlWord(17'h1FFFF, 1'b0, 1'b0, 1'b1), gainWord(5'd31, 5'd31),
                      32'hFFFF_FFFF, '0);
        streamCycles(80);
        if (wrapHighCount == highBefore) begin
            errorCount++;
            $display("integrator never wrapped above full scale");
        end
        lowBefore = wrapLowCount;
        sampleShift = 0;
        busWrite(agcCtrlAddr, ctrlWord('0, 1'b0, 1'b0, 1'b1), 4'hF);
        streamCycles(150);
        if (wrapLowCount == lowBefore) begin
            errorCount++;
            $display("integrator never wrapped below zero");
        end
        finishTest("limits and wrap clamping");

        r = nextRandom();
        sampleShift = int'(r[2:0]);
        configureLoop(ctrlWord(r[26:10], 1'b0, 1'b0, 1'b1),
                      gainWord({2'b01, r[2:0]}, {2'b01, r[6:4]}), 32'hFFFF_FFFF, '0);
        streamCycles(60);
        busWrite(agcCtrlAddr, ctrlWord(r[26:10], 1'b0, 1'b1, 1'b1), 4'hF);
        waitStrobes(3, 200);
        hold = loopOutput;
        for (int i = 0; i < 80; i++) begin
            stepCycle('0);
            if (loopOutput !== hold) begin
                errorCount++;
                $display("Fail loopOutput: got 0x%08h expected 0x%08h", loopOutput, hold);
            end
        end
        streamOn = 1'b0;
        readCheck(agcLevelAddr, '0, 1'b1);
        levelBefore = busRdData;
        repeat (30) stepCycle('0);
        readCheck(agcLevelAddr, '0, 1'b1);
        if (busRdData !== levelBefore) begin
            errorCount++;
            $display("Fail busRdData level: got 0x%08h expected 0x%08h", busRdData, levelBefore);
        end
        finishTest("freeze and strobe gaps");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
